/* hdl/arb_pkg.sv */
// Shared types for the two-class arbiter, imported by the RTL modules and the properties module
package arb_pkg;

    // Hold FSM used by both the urgent and the normal arbiter
    //   RESET  one cycle after srst, no grant
    //   GRANT  free to pick a new client
    //   HOLD   replay the registered grant until the held client acks
    typedef enum logic [1:0] {
        RESET,
        GRANT,
        HOLD
    } arb_state_t;

    // Which class currently owns the shared resource
    // FREE means neither arbiter holds a multi-cycle grant
    typedef enum logic [1:0] {
        FREE,
        OWN_PRIO,
        OWN_RR
    } owner_t;

    // Binary client index
    // 8 bits covers up to 256 clients
    typedef logic [7:0] client_idx_t;

endpackage : arb_pkg

/* hdl/arb_prio.sv */
// Urgent-class arbiter where the lowest requesting client wins and a grant is held until acked
module arb_prio
    import arb_pkg::*;
#(
    parameter int N = 4
) (
    input  logic         clk,
    input  logic         srst,
    input  logic         en,
    input  logic [N-1:0] req,
    input  logic [N-1:0] ack,
    output logic [N-1:0] grant,
    output client_idx_t  sel
);
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    arb_state_t state;
    arb_state_t nxt_state;

    // Winner of the priority search in the current cycle
    logic [IDX_W-1:0] pick;
    // Index presented on sel, held or freshly picked
    logic [IDX_W-1:0] cur_idx;
    logic             issue;

    // Held grant, loaded when a new grant goes out
    logic [IDX_W-1:0] sel_r;
    logic [N-1:0]     grant_r;

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    // Client 0 has the highest priority, so scan downward and let
    // the lowest requesting index overwrite the others
    always_comb begin
        pick = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick = IDX_W'(i);
            end
        end
    end

    // New grant only from GRANT state
    assign issue = (state == GRANT) && en && req[pick];

    always_comb begin
        nxt_state = state;
        case (state)
            RESET: begin
                nxt_state = GRANT;
            end
            GRANT: begin
                // Same-cycle ack keeps the arbiter free
                if (issue && !ack[pick]) begin
                    nxt_state = HOLD;
                end
            end
            HOLD: begin
                if (ack[sel_r]) begin
                    nxt_state = GRANT;
                end
            end
            default: begin
                nxt_state = RESET;
            end
        endcase
    end

    // One-hot grant, replayed while holding
    always_comb begin
        grant = '0;
        if (state == HOLD) begin
            grant = grant_r;
        end else if (issue) begin
            grant[pick] = 1'b1;
        end
    end

    assign cur_idx = (state == HOLD) ? sel_r : pick;
    assign sel     = client_idx_t'(cur_idx);

    always_ff @(posedge clk) begin
        if (issue) begin
            sel_r   <= pick;
            grant_r <= grant;
        end
    end

endmodule : arb_prio

/* hdl/arb_rr.sv */
// Normal-class round-robin arbiter that rotates from the last granted client and holds until ack
module arb_rr
    import arb_pkg::*;
#(
    parameter int N = 4
) (
    input  logic         clk,
    input  logic         srst,
    input  logic         en,
    input  logic [N-1:0] req,
    input  logic [N-1:0] ack,
    output logic [N-1:0] grant,
    output client_idx_t  sel
);
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    arb_state_t state;
    arb_state_t nxt_state;

    // Client granted most recently from GRANT state
    logic [IDX_W-1:0] last_r;

    // Winner of the rotating search in the current cycle
    logic [IDX_W-1:0] pick;
    logic [IDX_W-1:0] cur_idx;
    logic             issue;

    // Held grant
    logic [IDX_W-1:0] sel_r;
    logic [N-1:0]     grant_r;

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    // Search upward from last_r + 1 with wraparound.
    // Offsets are visited from far to near so the nearest requester is kept.
    always_comb begin : rr_search
        int cand;
        pick = '0;
        for (int i = N; i >= 1; i--) begin
            cand = (int'(last_r) + i) % N;
            if (req[cand]) begin
                pick = IDX_W'(cand);
            end
        end
    end

    assign issue = (state == GRANT) && en && req[pick];

    // Pointer moves only on a newly issued grant.
    // After reset it sits on N-1 so client 0 is searched first.
    always_ff @(posedge clk) begin
        if (srst) begin
            last_r <= IDX_W'(N - 1);
        end else if (issue) begin
            last_r <= pick;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            RESET: begin
                nxt_state = GRANT;
            end
            GRANT: begin
                if (issue && !ack[pick]) begin
                    nxt_state = HOLD;
                end
            end
            HOLD: begin
                // Ack cycle is the last cycle of the held grant
                if (ack[sel_r]) begin
                    nxt_state = GRANT;
                end
            end
            default: begin
                nxt_state = RESET;
            end
        endcase
    end

    always_comb begin
        grant = '0;
        if (state == HOLD) begin
            grant = grant_r;
        end else if (issue) begin
            grant[pick] = 1'b1;
        end
    end

    assign cur_idx = (state == HOLD) ? sel_r : pick;
    assign sel     = client_idx_t'(cur_idx);

    always_ff @(posedge clk) begin
        if (issue) begin
            sel_r   <= pick;
            grant_r <= grant;
        end
    end

endmodule : arb_rr

/* hdl/arb_class_combine.sv */
// Class combiner that enables one arbiter at a time, tracks the owning class and merges the grants
module arb_class_combine
    import arb_pkg::*;
#(
    parameter int N = 4
) (
    input  logic         clk,
    input  logic         srst,
    input  logic         en,
    input  logic [N-1:0] req_urgent,
    input  logic [N-1:0] ack,
    input  logic [N-1:0] prio_grant,
    input  client_idx_t  prio_sel,
    input  logic [N-1:0] rr_grant,
    input  client_idx_t  rr_sel,
    output logic         en_prio,
    output logic         en_rr,
    output logic [N-1:0] grant,
    output client_idx_t  sel,
    output logic         urgent
);
    owner_t owner_r;
    owner_t owner_nxt;

    logic urgent_pending;
    logic prio_active;
    logic rr_active;
    logic prio_acked;
    logic rr_acked;

    assign urgent_pending = |req_urgent;
    assign prio_active    = |prio_grant;
    assign rr_active      = |rr_grant;
    assign prio_acked     = |(prio_grant & ack);
    assign rr_acked       = |(rr_grant & ack);

    // Urgent class is blocked only by a held normal grant
    assign en_prio = en && (owner_r != OWN_RR);
    // Normal class yields to any pending urgent request and to a held urgent grant
    assign en_rr   = en && (owner_r != OWN_PRIO) && !urgent_pending;

    always_comb begin
        owner_nxt = owner_r;
        case (owner_r)
            FREE: begin
                if (prio_active && !prio_acked) begin
                    owner_nxt = OWN_PRIO;
                end else if (rr_active && !rr_acked) begin
                    owner_nxt = OWN_RR;
                end
            end
            OWN_PRIO: begin
                if (prio_acked) begin
                    owner_nxt = FREE;
                end
            end
            OWN_RR: begin
                if (rr_acked) begin
                    owner_nxt = FREE;
                end
            end
            default: begin
                owner_nxt = FREE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            owner_r <= FREE;
        end else begin
            owner_r <= owner_nxt;
        end
    end

    // The enables keep the two grants exclusive, so OR is enough
    assign grant  = prio_grant | rr_grant;
    assign urgent = prio_active;

    always_comb begin
        if (prio_active) begin
            sel = prio_sel;
        end else if (rr_active) begin
            sel = rr_sel;
        end else begin
            sel = '0;
        end
    end

endmodule : arb_class_combine

/* hdl/arb_two_class.sv */
// Two-class arbiter top level joining the urgent arbiter, the round-robin arbiter and the combiner
module arb_two_class
    import arb_pkg::*;
#(
    parameter int N = 4
) (
    input  logic         clk,
    input  logic         srst,
    input  logic         en,
    input  logic [N-1:0] req_urgent,
    input  logic [N-1:0] req_normal,
    input  logic [N-1:0] ack,
    output logic [N-1:0] grant,
    output client_idx_t  sel,
    output logic         urgent
);
    logic         en_prio;
    logic         en_rr;
    logic [N-1:0] prio_grant;
    logic [N-1:0] rr_grant;
    client_idx_t  prio_sel;
    client_idx_t  rr_sel;

    // Urgent class
    arb_prio #(
        .N(N)
    ) prio_i (
        .clk  (clk),
        .srst (srst),
        .en   (en_prio),
        .req  (req_urgent),
        .ack  (ack),
        .grant(prio_grant),
        .sel  (prio_sel)
    );

    // Normal class
    arb_rr #(
        .N(N)
    ) rr_i (
        .clk  (clk),
        .srst (srst),
        .en   (en_rr),
        .req  (req_normal),
        .ack  (ack),
        .grant(rr_grant),
        .sel  (rr_sel)
    );

    arb_class_combine #(
        .N(N)
    ) combine_i (
        .clk       (clk),
        .srst      (srst),
        .en        (en),
        .req_urgent(req_urgent),
        .ack       (ack),
        .prio_grant(prio_grant),
        .prio_sel  (prio_sel),
        .rr_grant  (rr_grant),
        .rr_sel    (rr_sel),
        .en_prio   (en_prio),
        .en_rr     (en_rr),
        .grant     (grant),
        .sel       (sel),
        .urgent    (urgent)
    );

endmodule : arb_two_class

/* verif/arb_two_class_properties.sv */
// Concurrent checks on the two-class arbiter outputs, bound into every arb_two_class instance
module arb_two_class_properties
    import arb_pkg::*;
#(
    parameter int N = 4
) (
    input logic         clk,
    input logic         srst,
    input logic [N-1:0] req_urgent,
    input logic [N-1:0] grant,
    input client_idx_t  sel,
    input logic         urgent,
    input logic [N-1:0] ack
);
    timeunit 1ns;
    timeprecision 100ps;

    grant_onehot_a: assert property (@(posedge clk) disable iff (srst) $onehot0(grant))
        else $error("grant has more than one bit set: %b", grant);

    // A grant without its ack carries over unchanged
    grant_hold_a: assert property (@(posedge clk) disable iff (srst)
        (grant != '0 && (grant & ack) == '0) |=> (grant == $past(grant)))
        else $error("held grant changed before its ack");

    // An urgent grant is backed by an urgent request or continues a held grant
    urgent_needs_grant_a: assert property (@(posedge clk) disable iff (srst)
        urgent |-> ((grant & req_urgent) != '0 || (grant != '0 && grant == $past(grant))))
        else $error("urgent high without an urgent request or a held grant");

    sel_matches_grant_a: assert property (@(posedge clk) disable iff (srst)
        (grant != '0) |-> ((grant >> sel) == N'(1)))
        else $error("sel %0d does not match grant %b", sel, grant);

endmodule : arb_two_class_properties

bind arb_two_class arb_two_class_properties #(
    .N(N)
) props_i (
    .clk       (clk),
    .srst      (srst),
    .req_urgent(req_urgent),
    .grant     (grant),
    .sel       (sel),
    .urgent    (urgent),
    .ack       (ack)
);

/* verif/arb_two_class_tb.sv */
// Testbench for the two-class arbiter; applies a table of stimulus rows and checks each cycle
module arb_two_class_tb
    import arb_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N            = 4;
    localparam int RESET_CYCLES = 5;

    logic         clk = 1'b0;
    logic         srst;
    logic         en;
    logic [N-1:0] req_urgent;
    logic [N-1:0] req_normal;
    logic [N-1:0] ack;
    logic [N-1:0] grant;
    client_idx_t  sel;
    logic         urgent;

    // Stimulus table, one entry per cycle
    logic         en_q[$];
    logic [N-1:0] ru_q[$];
    logic [N-1:0] rn_q[$];
    logic [N-1:0] ack_q[$];
    logic [N-1:0] exp_grant_q[$];
    client_idx_t  exp_sel_q[$];
    logic         exp_urgent_q[$];

    int row_errors  = 0;
    int pass_rows   = 0;
    int fail_rows   = 0;
    int cycle_count = 0;
    int cycle_limit = RESET_CYCLES + 20;

    arb_two_class #(
        .N(N)
    ) dut_i (
        .clk       (clk),
        .srst      (srst),
        .en        (en),
        .req_urgent(req_urgent),
        .req_normal(req_normal),
        .ack       (ack),
        .grant     (grant),
        .sel       (sel),
        .urgent    (urgent)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_row(input logic e, input logic [N-1:0] ru, input logic [N-1:0] rn,
                           input logic [N-1:0] a, input logic [N-1:0] g,
                           input client_idx_t s, input logic u);
        en_q.push_back(e);
        ru_q.push_back(ru);
        rn_q.push_back(rn);
        ack_q.push_back(a);
        exp_grant_q.push_back(g);
        exp_sel_q.push_back(s);
        exp_urgent_q.push_back(u);
    endtask

    // Columns: en, req_urgent, req_normal, ack, grant, sel, urgent
    task automatic build_table();
        // FSM still in RESET, then en low
        add_row(1'b1, 4'b0110, 4'b1011, 4'b0000, 4'b0000, 8'd0, 1'b0);
        add_row(1'b0, 4'b0110, 4'b1011, 4'b0000, 4'b0000, 8'd0, 1'b0);
        // Strict priority with same-cycle acks
        add_row(1'b1, 4'b0110, 4'b0000, 4'b0010, 4'b0010, 8'd1, 1'b1);
        add_row(1'b1, 4'b1101, 4'b0000, 4'b0001, 4'b0001, 8'd0, 1'b1);
        add_row(1'b1, 4'b1100, 4'b0000, 4'b0100, 4'b0100, 8'd2, 1'b1);
        add_row(1'b1, 4'b1000, 4'b0000, 4'b1000, 4'b1000, 8'd3, 1'b1);
        // Round robin over clients 0, 1 and 3, pointer starts at 3
        add_row(1'b1, 4'b0000, 4'b1011, 4'b0001, 4'b0001, 8'd0, 1'b0);
        add_row(1'b1, 4'b0000, 4'b1011, 4'b0010, 4'b0010, 8'd1, 1'b0);
        add_row(1'b1, 4'b0000, 4'b1011, 4'b1000, 4'b1000, 8'd3, 1'b0);
        add_row(1'b1, 4'b0000, 4'b1011, 4'b0001, 4'b0001, 8'd0, 1'b0);
        // Urgent grant on client 2 held through a higher request and a foreign ack
        add_row(1'b1, 4'b0100, 4'b0000, 4'b0000, 4'b0100, 8'd2, 1'b1);
        add_row(1'b1, 4'b0101, 4'b0000, 4'b0000, 4'b0100, 8'd2, 1'b1);
        add_row(1'b0, 4'b0001, 4'b0000, 4'b0001, 4'b0100, 8'd2, 1'b1);
        add_row(1'b1, 4'b0001, 4'b0000, 4'b0100, 4'b0100, 8'd2, 1'b1);
        add_row(1'b1, 4'b0001, 4'b0000, 4'b0001, 4'b0001, 8'd0, 1'b1);
        // Urgent beats normal when free
        add_row(1'b1, 4'b0010, 4'b1011, 4'b0010, 4'b0010, 8'd1, 1'b1);
        // Held normal grant on client 1 makes the urgent request wait
        add_row(1'b1, 4'b0000, 4'b1011, 4'b0000, 4'b0010, 8'd1, 1'b0);
        add_row(1'b1, 4'b0001, 4'b1011, 4'b0000, 4'b0010, 8'd1, 1'b0);
        add_row(1'b1, 4'b0001, 4'b1011, 4'b0010, 4'b0010, 8'd1, 1'b0);
        add_row(1'b1, 4'b0001, 4'b1011, 4'b0001, 4'b0001, 8'd0, 1'b1);
        add_row(1'b1, 4'b0000, 4'b1011, 4'b1000, 4'b1000, 8'd3, 1'b0);
        // Idle again
        add_row(1'b0, 4'b0000, 4'b0000, 4'b0000, 4'b0000, 8'd0, 1'b0);
    endtask

    task automatic check_grant(input logic [N-1:0] exp_val, input logic [N-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("Fail at %0t ns: grant expected %b, got %b", $time, exp_val, act_val);
            row_errors++;
        end
    endtask

    task automatic check_sel(input client_idx_t exp_val, input client_idx_t act_val);
        if (act_val !== exp_val) begin
            $display("Fail at %0t ns: sel expected %0d, got %0d", $time, exp_val, act_val);
            row_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp_val, act_val);
            row_errors++;
        end
    endtask

    initial begin : stimulus
        int num_rows;
        srst       = 1'b1;
        en         = 1'b0;
        req_urgent = '0;
        req_normal = '0;
        ack        = '0;
        build_table();
        num_rows    = en_q.size();
        cycle_limit = num_rows + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        srst = 1'b0;

        for (int r = 0; r < num_rows; r++) begin
            en         = en_q[r];
            req_urgent = ru_q[r];
            req_normal = rn_q[r];
            ack        = ack_q[r];
            // Sample just before the next edge
            #16;
            row_errors = 0;
            check_grant(exp_grant_q[r], grant);
            check_sel(exp_sel_q[r], sel);
            check_flag("urgent", exp_urgent_q[r], urgent);
            if (row_errors == 0) begin
                pass_rows++;
                $display("Row %0d ok: grant %b sel %0d urgent %b", r, grant, sel, urgent);
            end else begin
                fail_rows++;
                $display("Row %0d had %0d mismatches", r, row_errors);
            end
            @(posedge clk);
            #2;
        end

        $display("Rows run %0d, passed %0d, failed %0d", num_rows, pass_rows, fail_rows);
        if (fail_rows == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : arb_two_class_tb

/* list.f */
hdl/arb_pkg.sv
hdl/arb_prio.sv
hdl/arb_rr.sv
hdl/arb_class_combine.sv
hdl/arb_two_class.sv
verif/arb_two_class_properties.sv
verif/arb_two_class_tb.sv

/* Makefile */
# Verilator build and run for the two-class arbiter testbench

SIM := obj_dir/Varb_two_class_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): list.f $(wildcard hdl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module arb_two_class_tb -Mdir obj_dir -f list.f

# Pass or fail comes from the log, not from the simulator exit code
run: $(SIM)
	-$(SIM) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
